/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log
verilator --binary --timing --assert --top-module vp_tb -f sim.f -o vp_sim \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/vp_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation exited with error"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

/* sim.f */
vp_pkg.sv
vp_pixel_if.sv
vp_ctrl.sv
vp_luma.sv
vp_binarizer.sv
vp_composer.sv
vp_top.sv
vp_props.sv
vp_tb.sv

/* vp_binarizer.sv */
module vp_binarizer import vp_pkg::*; (
    input  logic    clk_vp,
    input  logic    rst_n,
    vp_ctrl_if.snk  cfg,
    vp_pixel_if.snk pix_in,
    vp_pixel_if.src pix_out
);

    logic        above;                             // Luma strictly over threshold
    logic        mark_c;
    logic        vs_q;
    logic        de_q;
    logic [23:0] rgb_q;
    logic [7:0]  luma_q;
    logic        mark_q;
    logic        win_q;

    assign above = pix_in.luma > cfg.bin_th;

    // Invert only on the explicit code, everything else counts as normal
    assign mark_c = (cfg.bin_mode == bin_invert) ? ~above : above;

    // --------------------
    // Stage register
    // --------------------
    always_ff @(posedge clk_vp) begin
        if (!rst_n) begin
            vs_q <= 1'b0;
            de_q <= 1'b0;
        end else begin
            vs_q <= pix_in.vs;
            de_q <= pix_in.de;
        end
    end

    always_ff @(posedge clk_vp) begin
        rgb_q  <= pix_in.rgb;                       // Pass through
        luma_q <= pix_in.luma;                      // Composer needs it for gray
        mark_q <= mark_c;
        win_q  <= pix_in.in_win;
    end

    assign pix_out.vs     = vs_q;
    assign pix_out.de     = de_q;
    assign pix_out.rgb    = rgb_q;
    assign pix_out.luma   = luma_q;
    assign pix_out.mark   = mark_q;
    assign pix_out.in_win = win_q;

endmodule

/* vp_composer.sv */
module vp_composer import vp_pkg::*; (
    input  logic        clk_vp,
    input  logic        rst_n,
    vp_ctrl_if.snk      cfg,
    vp_pixel_if.snk     pix_in,
    output logic        vp_vs,
    output logic        vp_de,
    output logic [15:0] vp_data                     // RGB565
);

    logic [15:0] pix_bypass;
    logic [15:0] pix_gray;
    logic [15:0] pix_bin;
    logic [15:0] pix_mode;                          // After mode select
    logic [15:0] pix_fill;                          // After window fill
    logic        cut;                               // Pixel is masked out

    // Truncate back to 565 which restores the input word
    assign pix_bypass = {pix_in.rgb[23:19], pix_in.rgb[15:10], pix_in.rgb[7:3]};

    // Same luma in all three channels
    assign pix_gray = {pix_in.luma[7:3], pix_in.luma[7:2], pix_in.luma[7:3]};

    assign pix_bin = pix_in.mark ? PIX_WHITE : PIX_BLACK;

    // --------------------
    // Mode and fill select
    // --------------------
    always_comb begin
        case (cfg.mode)
            mode_gray:   pix_mode = pix_gray;
            mode_binary: pix_mode = pix_bin;
            default:     pix_mode = pix_bypass;     // Code 11 too
        endcase
    end

    assign cut = cfg.cut_en & ~pix_in.in_win;

    always_comb begin
        pix_fill = pix_mode;
        if (cut) begin
            case (cfg.fill_mode)
                fill_black: pix_fill = PIX_BLACK;
                fill_white: pix_fill = PIX_WHITE;
                default:    pix_fill = pix_mode;    // No fill color chosen
            endcase
        end
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk_vp) begin
        if (!rst_n) begin
            vp_vs   <= 1'b0;
            vp_de   <= 1'b0;
            vp_data <= '0;
        end else begin
            vp_vs   <= pix_in.vs;
            vp_de   <= pix_in.de;
            vp_data <= pix_in.de ? pix_fill : 16'h0000;  // Quiet bus in blanking
        end
    end

endmodule

/* vp_ctrl.sv */
module vp_ctrl import vp_pkg::*; (
    input  logic        clk_vp,
    input  logic        rst_n,
    input  logic [31:0] vp_cr,
    input  logic [31:0] vp_start,
    input  logic [31:0] vp_end,
    input  logic [31:0] vp_threshold,
    input  logic        vi_vs,
    input  logic        vi_de,
    vp_ctrl_if.src      cfg,
    output logic        in_win
);

    logic               vs_d;                       // Previous vs for edge detect
    logic               de_d;                       // Previous de for end of line
    logic               vs_rise;
    logic               de_fall;
    ctrl_state_e        state;
    logic [COORD_W-1:0] x_cnt;                      // Index of current pixel in line
    logic [COORD_W-1:0] y_cnt;                      // Index of current line in frame

    // Latched frame settings
    vp_mode_e           mode_q;
    bin_mode_e          bin_mode_q;
    fill_mode_e         fill_mode_q;
    logic               cut_en_q;
    logic [7:0]         bin_th_q;
    logic [COORD_W-1:0] start_x;
    logic [COORD_W-1:0] start_y;
    logic [COORD_W-1:0] end_x;                      // Exclusive bound
    logic [COORD_W-1:0] end_y;                      // Exclusive bound
    logic               x_in;
    logic               y_in;

    assign vs_rise = vi_vs & ~vs_d;
    assign de_fall = de_d & ~vi_de;

    // --------------------
    // Coordinate counters
    // --------------------
    always_ff @(posedge clk_vp) begin
        if (!rst_n) begin
            vs_d  <= 1'b0;
            de_d  <= 1'b0;
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            vs_d <= vi_vs;
            de_d <= vi_de;
            if (vi_de)
                x_cnt <= x_cnt + 1'b1;              // Step through the de run
            else
                x_cnt <= '0;                        // Idle between lines
            if (vs_rise)
                y_cnt <= '0;                        // New frame starts at line 0
            else if (de_fall)
                y_cnt <= y_cnt + 1'b1;
        end
    end

    // --------------------
    // Frame latch
    // --------------------
    always_ff @(posedge clk_vp) begin
        if (!rst_n) begin
            state       <= st_wait_frame;
            mode_q      <= mode_bypass;
            bin_mode_q  <= bin_mode_e'(2'b00);
            fill_mode_q <= fill_mode_e'(2'b00);
            cut_en_q    <= 1'b0;
            bin_th_q    <= '0;
            start_x     <= '0;
            start_y     <= '0;
            end_x       <= '0;
            end_y       <= '0;
        end else if (vs_rise) begin
            // Register writes during a frame wait here until the next vs
            state       <= st_in_frame;
            mode_q      <= vp_mode_e'(vp_cr[CR_MODE_LSB +: 2]);
            bin_mode_q  <= bin_mode_e'(vp_cr[CR_BIN_LSB +: 2]);
            fill_mode_q <= fill_mode_e'(vp_cr[CR_FILL_LSB +: 2]);
            cut_en_q    <= vp_cr[CR_CUT_EN_BIT];
            bin_th_q    <= vp_threshold[TH_BIN_LSB +: 8];
            start_x     <= vp_start[COORD_W-1:0];
            start_y     <= vp_start[Y_LSB +: COORD_W];
            end_x       <= vp_end[COORD_W-1:0];
            end_y       <= vp_end[Y_LSB +: COORD_W];
        end
    end

    // Window test on the live input pixel
    assign x_in   = (x_cnt >= start_x) && (x_cnt < end_x);
    assign y_in   = (y_cnt >= start_y) && (y_cnt < end_y);
    assign in_win = (state == st_wait_frame) | (x_in & y_in);  // Whole screen before first vs

    assign cfg.mode      = mode_q;
    assign cfg.bin_mode  = bin_mode_q;
    assign cfg.fill_mode = fill_mode_q;
    assign cfg.cut_en    = cut_en_q;
    assign cfg.bin_th    = bin_th_q;

endmodule

/* vp_luma.sv */
module vp_luma import vp_pkg::*; (
    input  logic        clk_vp,
    input  logic        rst_n,
    input  logic        vi_vs,
    input  logic        vi_de,
    input  logic [15:0] vi_data,                    // RGB565
    input  logic        in_win,
    vp_pixel_if.src     pix_out
);

    logic [7:0]  r8;
    logic [7:0]  g8;
    logic [7:0]  b8;
    logic [15:0] luma_sum;                          // Fixed point, 8 fraction bits
    logic        vs_q;
    logic        de_q;
    logic [23:0] rgb_q;
    logic [7:0]  luma_q;
    logic        win_q;

    // Zero padded expansion to RGB888
    assign r8 = {vi_data[15:11], 3'b000};
    assign g8 = {vi_data[10:5], 2'b00};
    assign b8 = {vi_data[4:0], 3'b000};

    // Largest sum is 64088 so 16 bits never overflow
    assign luma_sum = {8'd0, r8} * {8'd0, LUMA_WR}
                    + {8'd0, g8} * {8'd0, LUMA_WG}
                    + {8'd0, b8} * {8'd0, LUMA_WB};

    // --------------------
    // Stage register
    // --------------------
    always_ff @(posedge clk_vp) begin
        if (!rst_n) begin
            vs_q <= 1'b0;
            de_q <= 1'b0;
        end else begin
            vs_q <= vi_vs;
            de_q <= vi_de;
        end
    end

    // Payload registers, qualified by de_q
    always_ff @(posedge clk_vp) begin
        rgb_q  <= {r8, g8, b8};
        luma_q <= luma_sum[15:8];                   // Drop fraction
        win_q  <= in_win;
    end

    assign pix_out.vs     = vs_q;
    assign pix_out.de     = de_q;
    assign pix_out.rgb    = rgb_q;
    assign pix_out.luma   = luma_q;
    assign pix_out.mark   = 1'b0;                   // Filled in by the binarizer
    assign pix_out.in_win = win_q;

endmodule

/* vp_pixel_if.sv */
// One pixel plus sideband between two pipeline stages
interface vp_pixel_if;
    logic        vs;                                // Frame sync
    logic        de;                                // Pixel valid strobe
    logic [23:0] rgb;                               // Expanded RGB888
    logic [7:0]  luma;
    logic        mark;                              // Binarizer result
    logic        in_win;                            // Pixel lies in crop window

    modport src (output vs, de, rgb, luma, mark, in_win);
    modport snk (input vs, de, rgb, luma, mark, in_win);
endinterface

// Per-frame configuration from the control block to the datapath
interface vp_ctrl_if import vp_pkg::*; ();
    vp_mode_e   mode;
    bin_mode_e  bin_mode;
    fill_mode_e fill_mode;
    logic       cut_en;
    logic [7:0] bin_th;

    // Only vp_ctrl drives
    modport src (output mode, bin_mode, fill_mode, cut_en, bin_th);
    modport snk (input mode, bin_mode, fill_mode, cut_en, bin_th);
endinterface

/* vp_pkg.sv */
package vp_pkg;

    // --------------------
    // Geometry
    // --------------------
    localparam int unsigned COORD_W = 11;           // Pixel and line counter width

    // --------------------
    // Register field positions
    // --------------------
    localparam int unsigned CR_MODE_LSB   = 1;      // vp_cr[2:1] output mode
    localparam int unsigned CR_CUT_EN_BIT = 3;      // vp_cr[3] window cut enable
    localparam int unsigned CR_BIN_LSB    = 19;     // vp_cr[20:19] binarizer polarity
    localparam int unsigned CR_FILL_LSB   = 22;     // vp_cr[23:22] fill color
    localparam int unsigned TH_BIN_LSB    = 8;      // vp_threshold[15:8] binarizer level
    localparam int unsigned Y_LSB         = 16;     // y corner starts here in start and end words

    // Luma weights in 1/256 units, sum is exactly 256
    localparam logic [7:0] LUMA_WR = 8'd77;
    localparam logic [7:0] LUMA_WG = 8'd150;
    localparam logic [7:0] LUMA_WB = 8'd29;

    // RGB565 fill words
    localparam logic [15:0] PIX_WHITE = 16'hffff;
    localparam logic [15:0] PIX_BLACK = 16'h0000;

    // --------------------
    // Encodings
    // --------------------
    typedef enum logic [1:0] {
        mode_bypass = 2'b00,                        // 11 decodes the same way
        mode_gray   = 2'b01,
        mode_binary = 2'b10
    } vp_mode_e;

    typedef enum logic [1:0] {
        bin_normal = 2'b01,                         // Mark when luma above threshold
        bin_invert = 2'b10                          // Mark when luma at or below threshold
    } bin_mode_e;

    typedef enum logic [1:0] {
        fill_black = 2'b01,
        fill_white = 2'b10                          // 00 and 11 leave the pixel alone
    } fill_mode_e;

    typedef enum logic {
        st_wait_frame = 1'b0,                       // No vs seen since reset
        st_in_frame   = 1'b1
    } ctrl_state_e;

endpackage

/* vp_props.sv */
module vp_props (
    input logic clk_vp,
    input logic rst_n,
    input logic vi_vs,
    input logic vi_de,
    input logic vp_vs,
    input logic vp_de
);

    // Strobes trail the input by the three stages
    de_follows_input: assert property (@(posedge clk_vp) disable iff (!rst_n)
        vp_de == $past(vi_de, 3))
        else $error("vp_de is not vi_de delayed by 3 cycles");

    vs_follows_input: assert property (@(posedge clk_vp) disable iff (!rst_n)
        vp_vs == $past(vi_vs, 3))
        else $error("vp_vs is not vi_vs delayed by 3 cycles");

    // Sync and pixel strobe are exclusive
    vs_de_exclusive: assert property (@(posedge clk_vp) disable iff (!rst_n)
        !(vp_vs && vp_de))
        else $error("vp_vs and vp_de high in the same cycle");

    quiet_after_reset: assert property (@(posedge clk_vp)
        $rose(rst_n) |-> !vp_de ##1 !vp_de ##1 !vp_de)
        else $error("vp_de high within 3 cycles of reset release");

endmodule

bind vp_top vp_props i_props (
    .clk_vp (clk_vp),
    .rst_n  (rst_n),
    .vi_vs  (vi_vs),
    .vi_de  (vi_de),
    .vp_vs  (vp_vs),
    .vp_de  (vp_de)
);

/* vp_tb.sv */
module vp_tb import vp_pkg::*; ();

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 5;
    localparam int FRAME_W        = 12;
    localparam int FRAME_H        = 8;
    localparam int LINE_GAP       = 3;              // Idle cycles after each line
    localparam int PRE_VS_IDLE    = 4;              // Last pixel clears the pipe before a latch
    localparam int N_FRAMES       = 12;
    localparam int FRAME_CYCLES   = PRE_VS_IDLE + 2 + FRAME_H * (FRAME_W + LINE_GAP);
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_FRAMES * FRAME_CYCLES + 100;

    logic        clk_vp;
    logic        rst_n;
    logic [31:0] vp_cr;
    logic [31:0] vp_start;
    logic [31:0] vp_end;
    logic [31:0] vp_threshold;
    logic        vi_vs;
    logic        vi_de;
    logic [15:0] vi_data;
    logic        vp_vs;
    logic        vp_de;
    logic [15:0] vp_data;

    logic [31:0] lfsr;                              // Stimulus generator state
    logic [15:0] exp_q[$];                          // Expected words in output order
    int          in_count;
    int          out_count;
    int          err_count;
    logic [31:0] lat_cr;                            // Words the DUT took at the last vs
    logic [31:0] lat_th;
    logic [31:0] lat_st;
    logic [31:0] lat_en;

    vp_top i_dut (
        .clk_vp       (clk_vp),
        .rst_n        (rst_n),
        .vp_cr        (vp_cr),
        .vp_start     (vp_start),
        .vp_end       (vp_end),
        .vp_threshold (vp_threshold),
        .vi_vs        (vi_vs),
        .vi_de        (vi_de),
        .vi_data      (vi_data),
        .vp_vs        (vp_vs),
        .vp_de        (vp_de),
        .vp_data      (vp_data)
    );

    initial begin
        clk_vp = 1'b0;
        forever #(CLK_PERIOD / 2) clk_vp = ~clk_vp;
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [15:0] expected_pixel(
        input logic [15:0] pix,
        input logic [31:0] cr,
        input logic [31:0] th,
        input logic [31:0] st,
        input logic [31:0] en,
        input int          x,
        input int          y
    );
        int          sum;
        logic [7:0]  luma;
        logic        mark;
        logic        in_window;
        logic [1:0]  fill;
        logic [15:0] res;
        sum  = int'({pix[15:11], 3'b000}) * int'(LUMA_WR)
             + int'({pix[10:5], 2'b00}) * int'(LUMA_WG)
             + int'({pix[4:0], 3'b000}) * int'(LUMA_WB);
        luma = 8'(sum >> 8);                        // Integer part of the weighted sum
        mark = luma > th[TH_BIN_LSB +: 8];
        if (cr[CR_BIN_LSB +: 2] == bin_invert)
            mark = ~mark;                           // At or below the level
        case (cr[CR_MODE_LSB +: 2])
            mode_gray:   res = {luma[7:3], luma[7:2], luma[7:3]};
            mode_binary: res = mark ? PIX_WHITE : PIX_BLACK;
            default:     res = pix;                 // Bypass, code 11 too
        endcase
        in_window = x >= int'(st[COORD_W-1:0]) && x < int'(en[COORD_W-1:0])
                 && y >= int'(st[Y_LSB +: COORD_W]) && y < int'(en[Y_LSB +: COORD_W]);
        fill = cr[CR_FILL_LSB +: 2];
        if (cr[CR_CUT_EN_BIT] && !in_window && fill == fill_black)
            res = PIX_BLACK;
        else if (cr[CR_CUT_EN_BIT] && !in_window && fill == fill_white)
            res = PIX_WHITE;
        return res;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_pixel(output logic [15:0] w);
        w = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_next(lfsr);                 // One step per bit
            w    = {w[14:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] make_cr(input logic [1:0] mode, input logic [1:0] bin,
                                            input logic [1:0] fill, input logic cut);
        return (32'(mode) << CR_MODE_LSB) | (32'(bin) << CR_BIN_LSB)
             | (32'(fill) << CR_FILL_LSB) | (32'(cut) << CR_CUT_EN_BIT);
    endfunction

    function automatic logic [31:0] make_xy(input int x, input int y);
        return 32'(x) | (32'(y) << Y_LSB);
    endfunction

    function automatic logic [31:0] make_th(input logic [7:0] level);
        return 32'(level) << TH_BIN_LSB;
    endfunction

    task automatic set_regs(input logic [31:0] cr, th, st, en);
        vp_cr        = cr;
        vp_threshold = th;
        vp_start     = st;
        vp_end       = en;
    endtask

    // --------------------
    // Frame generator
    // --------------------
    task automatic send_frame(
        input bit          mid_change,               // Rewrite the words halfway down
        input logic [31:0] cr2,
        input logic [31:0] th2,
        input logic [31:0] st2,
        input logic [31:0] en2
    );
        logic [15:0] pix;
        repeat (PRE_VS_IDLE) @(negedge clk_vp);
        vi_vs  = 1'b1;
        lat_cr = vp_cr;                              // DUT samples these on this vs
        lat_th = vp_threshold;
        lat_st = vp_start;
        lat_en = vp_end;
        @(negedge clk_vp);
        vi_vs = 1'b0;
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                @(negedge clk_vp);
                if (mid_change && y == FRAME_H / 2 && x == 0)
                    set_regs(cr2, th2, st2, en2);    // Held off until the next vs
                random_pixel(pix);
                vi_de   = 1'b1;
                vi_data = pix;
                exp_q.push_back(expected_pixel(pix, lat_cr, lat_th, lat_st, lat_en, x, y));
                in_count++;
            end
            @(negedge clk_vp);
            vi_de   = 1'b0;
            vi_data = '0;
            repeat (LINE_GAP - 1) @(negedge clk_vp);
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        rst_n     = 1'b0;
        vi_vs     = 1'b0;
        vi_de     = 1'b0;
        vi_data   = '0;
        set_regs('0, '0, '0, '0);
        lfsr      = 32'ha8f7_549e;
        in_count  = 0;
        out_count = 0;
        err_count = 0;
        repeat (RESET_CYCLES) @(negedge clk_vp);
        rst_n = 1'b1;

        set_regs(make_cr(mode_bypass, bin_normal, 2'b00, 1'b0), '0, '0,
                 make_xy(FRAME_W, FRAME_H));
        send_frame(1'b0, '0, '0, '0, '0);
        set_regs(make_cr(mode_gray, bin_normal, 2'b00, 1'b0), '0, '0,
                 make_xy(FRAME_W, FRAME_H));
        send_frame(1'b0, '0, '0, '0, '0);

        // Levels 40, 120, 200 in both polarities
        for (int i = 0; i < 3; i++) begin
            for (int p = 0; p < 2; p++) begin
                set_regs(make_cr(mode_binary, p ? bin_invert : bin_normal, 2'b00, 1'b0),
                         make_th(8'(40 + 80 * i)), '0, make_xy(FRAME_W, FRAME_H));
                send_frame(1'b0, '0, '0, '0, '0);
            end
        end

        // Window cut with black then white fill
        set_regs(make_cr(mode_gray, bin_normal, fill_black, 1'b1), '0,
                 make_xy(3, 2), make_xy(9, 6));
        send_frame(1'b0, '0, '0, '0, '0);
        set_regs(make_cr(mode_bypass, bin_normal, fill_white, 1'b1), '0,
                 make_xy(3, 2), make_xy(9, 6));
        send_frame(1'b0, '0, '0, '0, '0);

        // Words rewritten mid-frame apply from the following frame only
        set_regs(make_cr(mode_gray, bin_normal, fill_white, 1'b1), '0,
                 make_xy(2, 1), make_xy(10, 7));
        send_frame(1'b1, make_cr(mode_binary, bin_invert, fill_black, 1'b1),
                   make_th(8'd90), make_xy(4, 3), make_xy(8, 5));
        send_frame(1'b0, '0, '0, '0, '0);

        while (exp_q.size() != 0) @(negedge clk_vp);  // Drain the pipeline
        repeat (4) @(negedge clk_vp);                 // Room for a stray extra pixel
        if (out_count != in_count) begin
            $display("Pixel count mismatch: %0d pixels sent, %0d received",
                     in_count, out_count);
            err_count++;
        end
        $display("Pixels in %0d, pixels out %0d, errors %0d", in_count, out_count, err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // --------------------
    // Output checker
    // --------------------
    always @(negedge clk_vp) begin
        logic [15:0] exp_pix;
        if (vp_de) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("Extra output pixel at time %0t with no input pixel left", $time);
                err_count++;
            end else begin
                exp_pix = exp_q.pop_front();
                if (vp_data !== exp_pix) begin
                    $display("CHECK FAILED at %0t: pixel %0d is %h, expected %h",
                             $time, out_count, vp_data, exp_pix);
                    err_count++;
                end
            end
        end else if (vp_data !== 16'h0000) begin
            $display("CHECK FAILED at %0t: data %h in blanking, expected 0000",
                     $time, vp_data);
            err_count++;
        end
    end

    // Watchdog sized from the frame count
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles with %0d pixels still awaited",
                 TIMEOUT_CYCLES, exp_q.size());
        $display("Regression failed");
        $finish;
    end

endmodule

/* vp_top.sv */
module vp_top (
    input  logic        clk_vp,
    input  logic        rst_n,

    // Configuration words
    input  logic [31:0] vp_cr,
    input  logic [31:0] vp_start,
    input  logic [31:0] vp_end,
    input  logic [31:0] vp_threshold,

    // Video in
    input  logic        vi_vs,
    input  logic        vi_de,
    input  logic [15:0] vi_data,

    // Video out, 3 cycles behind video in
    output logic        vp_vs,
    output logic        vp_de,
    output logic [15:0] vp_data
);

    vp_ctrl_if  cfg_if ();
    vp_pixel_if luma_if ();                         // vp_luma to vp_binarizer
    vp_pixel_if bin_if ();                          // vp_binarizer to vp_composer
    logic       in_win;                             // Combinational from ctrl

    vp_ctrl i_ctrl (
        .clk_vp       (clk_vp),
        .rst_n        (rst_n),
        .vp_cr        (vp_cr),
        .vp_start     (vp_start),
        .vp_end       (vp_end),
        .vp_threshold (vp_threshold),
        .vi_vs        (vi_vs),
        .vi_de        (vi_de),
        .cfg          (cfg_if.src),
        .in_win       (in_win)
    );

    // Stage 1
    vp_luma i_luma (
        .clk_vp  (clk_vp),
        .rst_n   (rst_n),
        .vi_vs   (vi_vs),
        .vi_de   (vi_de),
        .vi_data (vi_data),
        .in_win  (in_win),
        .pix_out (luma_if.src)
    );

    // Stage 2
    vp_binarizer i_binarizer (
        .clk_vp  (clk_vp),
        .rst_n   (rst_n),
        .cfg     (cfg_if.snk),
        .pix_in  (luma_if.snk),
        .pix_out (bin_if.src)
    );

    // Stage 3
    vp_composer i_composer (
        .clk_vp  (clk_vp),
        .rst_n   (rst_n),
        .cfg     (cfg_if.snk),
        .pix_in  (bin_if.snk),
        .vp_vs   (vp_vs),
        .vp_de   (vp_de),
        .vp_data (vp_data)
    );

endmodule
